// File: list.f
+incdir+.
bch_pkg.sv
channel_pkg.sv
bch_encoder.sv
noise_source.sv
channel_impairment.sv
channel_sequencer.sv
channel_top.sv
tb_channel_top.sv

// File: Makefile
# Verilator build and run of the channel testbench

VERILATOR ?= verilator
TOP       ?= tb_channel_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_channel_top.sv
`default_nettype none

`include "channel_settings.svh"

module tb_channel_top
    import bch_pkg::*, channel_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_W    = $bits(bch_frame_t);
    localparam int PAR_W      = `BCH_N - `BCH_K;
    localparam int N_DIRECTED = 12;
    localparam int N_RANDOM   = 40;
    localparam int N_CMDS     = N_DIRECTED + N_RANDOM;
    localparam int MAX_CYCLES = N_CMDS * 2000;
    localparam logic [`BCH_N-1:0] GEN_EXT = {{(`BCH_N - PAR_W - 1){1'b0}}, `BCH_GEN};

    logic            clk;
    logic            rst;
    channel_cmd_t    cmd;
    logic            cmd_valid;
    channel_result_t result;
    logic            out_ready;

    integer       seed       = 32'h53c10741;
    int           errors     = 0;
    int           results    = 0;
    int           accepted   = 0;
    int           cycles     = 0;
    logic         ready_seen = 1'b0;
    channel_cmd_t sent_q[$];

    channel_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .result    (result),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    // long division of msg * x^10 by the generator
    function automatic bch_cw_t ref_bch(input bch_msg_t msg);
        logic [`BCH_N-1:0] work;
        int                i;
        work = {msg, {PAR_W{1'b0}}};
        for (i = `BCH_N - 1; i >= PAR_W; i--) begin
            if (work[i]) begin
                work = work ^ (GEN_EXT << (i - PAR_W));
            end
        end
        return {msg, work[PAR_W-1:0]};
    endfunction

    function automatic int count_ones(input logic [FRAME_W-1:0] v);
        int n;
        int i;
        n = 0;
        for (i = 0; i < FRAME_W; i++) begin
            n += int'(v[i]);
        end
        return n;
    endfunction

    function automatic channel_cmd_t make_cmd(input ch_byte_t data, input logic bch,
                                              input logic noise, input logic errs,
                                              input ch_byte_t density, input ch_byte_t count);
        channel_cmd_t c;
        c.data       = data;
        c.use_bch    = bch;
        c.use_noise  = noise;
        c.use_errors = errs;
        c.density    = density;
        c.err_count  = count;
        return c;
    endfunction

    task automatic make_random_cmd(output channel_cmd_t c);
        logic [31:0] a;
        logic [31:0] b;
        a = $random(seed);
        b = $random(seed);
        c = make_cmd(a[7:0], a[8], a[9], a[10], b[7:0], {2'b00, b[13:8]});
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h", name, got, exp);
        end
    endtask

    // expected behavior of one result, derived from its command
    task automatic check_result(input channel_cmd_t c, input channel_result_t r);
        bch_frame_t         exp_frame;
        logic [FRAME_W-1:0] diff;
        logic [FRAME_W-1:0] allowed;
        int                 width;
        int                 limit;
        int                 i;
        logic               exact;
        exp_frame.hi = ref_bch(bch_msg_t'(c.data[7:4]));
        exp_frame.lo = ref_bch(bch_msg_t'(c.data[3:0]));
        for (i = 0; i < FRAME_W; i++) begin
            allowed[i] = c.density[i % `CH_DATA_W];
        end
        width = c.use_bch ? FRAME_W : `CH_DATA_W;
        limit = (int'(c.err_count) < width) ? int'(c.err_count) : width;
        // noise with density zero leaves the error count exact
        exact = c.use_errors && (!c.use_noise || c.density == '0);
        if (c.use_bch) begin
            diff = exp_frame ^ r.frame;
            // data bits carry only the flips that hit the message nibbles
            check_value("result.data_out", r.data_out,
                        c.data ^ {diff[`BCH_N + PAR_W +: 4], diff[PAR_W +: 4]});
        end else begin
            diff = FRAME_W'(r.data_out ^ c.data);
            check_value("result.frame", r.frame, '0);
        end
        if (!c.use_noise && !c.use_errors) begin
            check_value("result changed bits", diff, '0);
        end else if (exact) begin
            check_value("result flipped bit count", count_ones(diff), limit);
        end else if (!c.use_errors) begin
            check_value("result bits outside density", diff & ~allowed, '0);
        end
    endtask

    // one command; optional stray strobe rise while it runs
    task automatic send_cmd(input channel_cmd_t c, input logic stray);
        int   waited;
        logic was_ready;
        @(posedge clk);
        was_ready = ready_seen;
        cmd       <= c;
        cmd_valid <= 1'b1;
        sent_q.push_back(c);
        accepted++;
        @(posedge clk);
        cmd_valid <= 1'b0;
        if (stray) begin
            repeat (2) @(posedge clk);
            cmd       <= make_cmd(8'hff, 1'b0, 1'b0, 1'b0, 8'h00, 8'h00);
            cmd_valid <= 1'b1;
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
        if (was_ready) begin
            waited = 0;
            while (ready_seen && waited < 8) begin
                @(posedge clk);
                waited++;
            end
            if (ready_seen) begin
                errors++;
                $display("out_ready stayed high after a new command was captured");
            end
        end
        while (results < accepted) begin
            @(posedge clk);
        end
    endtask

    // ------------------------------
    // compare process
    // ------------------------------
    initial begin
        channel_result_t held;
        held = '0;
        forever begin
            @(negedge clk);
            if (out_ready && !ready_seen) begin
                results++;
                held = result;
                if (sent_q.size() == 0) begin
                    errors++;
                    $display("out_ready rose with no command outstanding");
                end else begin
                    check_result(sent_q.pop_front(), result);
                end
            end else if (out_ready) begin
                // result stays put until out_ready falls
                check_value("result", result, held);
            end
            ready_seen = out_ready;
        end
    end

    // watchdog
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles without finishing", cycles);
        $display("*** FAILED ***");
        $finish;
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        channel_cmd_t c;
        int           k;
        rst       = 1'b1;
        cmd       = '0;
        cmd_valid = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("out_ready", out_ready, 1'b0);

        send_cmd(make_cmd(8'ha5, 1'b0, 1'b0, 1'b0, 8'h00, 8'h00), 1'b0);
        send_cmd(make_cmd(8'h3c, 1'b1, 1'b0, 1'b0, 8'h00, 8'h00), 1'b0);
        // noise only
        send_cmd(make_cmd(8'h96, 1'b0, 1'b1, 1'b0, 8'h00, 8'h00), 1'b0);
        send_cmd(make_cmd(8'h0f, 1'b0, 1'b1, 1'b0, 8'h5a, 8'h00), 1'b0);
        send_cmd(make_cmd(8'hc3, 1'b1, 1'b1, 1'b0, 8'h81, 8'h00), 1'b0);
        // errors only, counts below and above the position count
        send_cmd(make_cmd(8'h55, 1'b0, 1'b0, 1'b1, 8'h00, 8'd3), 1'b0);
        send_cmd(make_cmd(8'haa, 1'b0, 1'b0, 1'b1, 8'h00, 8'd20), 1'b0);
        send_cmd(make_cmd(8'h7e, 1'b1, 1'b0, 1'b1, 8'h00, 8'd5), 1'b0);
        send_cmd(make_cmd(8'h81, 1'b1, 1'b0, 1'b1, 8'h00, 8'd200), 1'b0);
        send_cmd(make_cmd(8'h42, 1'b1, 1'b0, 1'b1, 8'h00, 8'd0), 1'b0);
        send_cmd(make_cmd(8'he7, 1'b1, 1'b1, 1'b1, 8'h00, 8'd7), 1'b0);
        // strobe rise during encoding must be ignored
        send_cmd(make_cmd(8'h19, 1'b1, 1'b0, 1'b1, 8'h00, 8'd30), 1'b1);

        for (k = 0; k < N_RANDOM; k++) begin
            make_random_cmd(c);
            send_cmd(c, 1'b0);
        end

        repeat (20) @(posedge clk);
        check_value("out_ready rise count", results, accepted);
        $display("run complete with %0d errors over %0d results", errors, results);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: channel_top.sv
`default_nettype none

module channel_top
    import bch_pkg::*, channel_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  channel_cmd_t    cmd,
    input  logic            cmd_valid,
    output channel_result_t result,
    output logic            out_ready
);

    localparam int FRAME_W = $bits(bch_frame_t);

    bch_msg_t           hi_msg;
    bch_msg_t           lo_msg;
    bch_cw_t            hi_cw;
    bch_cw_t            lo_cw;
    logic               enc_start;
    logic               enc_done;
    logic               noise_go;
    logic               noise_done;
    logic               err_go;
    logic               err_done;
    logic               coded;
    logic [31:0]        rnd;
    logic [FRAME_W-1:0] word_in;
    logic [FRAME_W-1:0] impaired;
    ch_byte_t           density;
    ch_byte_t           err_count;

    channel_sequencer seq_i (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .hi_cw      (hi_cw),
        .lo_cw      (lo_cw),
        .enc_done   (enc_done),
        .impaired   (impaired),
        .noise_done (noise_done),
        .err_done   (err_done),
        .enc_start  (enc_start),
        .noise_go   (noise_go),
        .err_go     (err_go),
        .coded      (coded),
        .word_in    (word_in),
        .density    (density),
        .err_count  (err_count),
        .hi_msg     (hi_msg),
        .lo_msg     (lo_msg),
        .result     (result),
        .out_ready  (out_ready)
    );

    // ------------------------------
    // encoders
    // ------------------------------
    // enc_hi runs in lockstep with enc_lo, one done is enough
    bch_encoder enc_hi (
        .clk   (clk),
        .rst   (rst),
        .start (enc_start),
        .msg   (hi_msg),
        .cw    (hi_cw),
        .done  ()
    );

    bch_encoder enc_lo (
        .clk   (clk),
        .rst   (rst),
        .start (enc_start),
        .msg   (lo_msg),
        .cw    (lo_cw),
        .done  (enc_done)
    );

    noise_source noise_i (
        .clk (clk),
        .rst (rst),
        .rnd (rnd)
    );

    channel_impairment #(
        .WORD_W (FRAME_W)
    ) imp_i (
        .clk        (clk),
        .rst        (rst),
        .rnd        (rnd),
        .coded      (coded),
        .word_in    (word_in),
        .density    (density),
        .err_count  (err_count),
        .noise_go   (noise_go),
        .err_go     (err_go),
        .word_out   (impaired),
        .noise_done (noise_done),
        .err_done   (err_done)
    );

endmodule

`default_nettype wire

// File: channel_sequencer.sv
`default_nettype none

module channel_sequencer
    import bch_pkg::*, channel_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  channel_cmd_t                  cmd,
    input  logic                          cmd_valid,
    input  bch_cw_t                       hi_cw,
    input  bch_cw_t                       lo_cw,
    input  logic                          enc_done,
    input  logic [$bits(bch_frame_t)-1:0] impaired,
    input  logic                          noise_done,
    input  logic                          err_done,
    output logic                          enc_start,
    output logic                          noise_go,
    output logic                          err_go,
    output logic                          coded,
    output logic [$bits(bch_frame_t)-1:0] word_in,
    output ch_byte_t                      density,
    output ch_byte_t                      err_count,
    output bch_msg_t                      hi_msg,
    output bch_msg_t                      lo_msg,
    output channel_result_t               result,
    output logic                          out_ready
);

    localparam int FRAME_W = $bits(bch_frame_t);
    localparam int BYTE_W  = $bits(ch_byte_t);
    localparam int NIB_W   = BYTE_W / 2;
    localparam int PAR_W   = $bits(bch_cw_t) - $bits(bch_msg_t);

    stage_t       stage;
    stage_t       stage_nxt;
    channel_cmd_t cmd_q;
    logic         valid_q;
    logic         accept;
    logic         impaired_used;
    bch_frame_t   frame_in;
    bch_frame_t   frame_out;

    // first enabled stage after the given one
    function automatic stage_t next_stage(input stage_t from, input channel_cmd_t c);
        stage_t nxt;
        nxt = FINISHED;
        if (c.use_errors && from != ERRORS) nxt = ERRORS;
        if (c.use_noise && (from == IDLE || from == FINISHED || from == ENCODING)) nxt = NOISE;
        if (c.use_bch && (from == IDLE || from == FINISHED)) nxt = ENCODING;
        return nxt;
    endfunction

    // strobe rise, ignored while a command is in flight
    assign accept = cmd_valid && !valid_q && (stage == IDLE || (stage == FINISHED && out_ready));

    always_comb begin
        stage_nxt = stage;
        case (stage)
            IDLE, FINISHED: if (accept) stage_nxt = next_stage(stage, cmd);
            ENCODING:       if (enc_done) stage_nxt = next_stage(stage, cmd_q);
            NOISE:          if (noise_done) stage_nxt = next_stage(stage, cmd_q);
            ERRORS:         if (err_done) stage_nxt = next_stage(stage, cmd_q);
            default:        stage_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage     <= IDLE;
            cmd_q     <= '0;
            valid_q   <= 1'b0;
            enc_start <= 1'b0;
            noise_go  <= 1'b0;
            err_go    <= 1'b0;
            out_ready <= 1'b0;
        end else begin
            valid_q   <= cmd_valid;
            stage     <= stage_nxt;
            // one strobe on entry to each working stage
            enc_start <= (stage_nxt == ENCODING) && (stage != ENCODING);
            noise_go  <= (stage_nxt == NOISE) && (stage != NOISE);
            err_go    <= (stage_nxt == ERRORS) && (stage != ERRORS);
            if (accept) begin
                cmd_q     <= cmd;
                out_ready <= 1'b0;
            end else if (stage == FINISHED && !out_ready) begin
                out_ready <= 1'b1;
            end
        end
    end

    // ------------------------------
    // data toward the workers
    // ------------------------------
    assign frame_in.hi   = hi_cw;
    assign frame_in.lo   = lo_cw;
    assign impaired_used = cmd_q.use_noise | cmd_q.use_errors;
    assign frame_out     = impaired_used ? bch_frame_t'(impaired) : frame_in;

    assign coded     = cmd_q.use_bch;
    assign density   = cmd_q.density;
    assign err_count = cmd_q.err_count;
    assign hi_msg    = bch_msg_t'(cmd_q.data[BYTE_W-1 -: NIB_W]);
    assign lo_msg    = bch_msg_t'(cmd_q.data[NIB_W-1:0]);

    // errors after noise work on the noisy word
    assign word_in = (stage == ERRORS && cmd_q.use_noise) ? impaired :
                     cmd_q.use_bch ? frame_in : FRAME_W'(cmd_q.data);

    always_ff @(posedge clk) begin
        if (stage == FINISHED && !out_ready) begin
            if (cmd_q.use_bch) begin
                result.frame    <= frame_out;
                // uncorrected systematic bits
                result.data_out <= {frame_out.hi[PAR_W +: NIB_W], frame_out.lo[PAR_W +: NIB_W]};
            end else begin
                result.frame    <= '0;
                result.data_out <= impaired_used ? impaired[BYTE_W-1:0] : cmd_q.data;
            end
        end
    end

endmodule

`default_nettype wire

// File: channel_impairment.sv
`default_nettype none

module channel_impairment
    import channel_pkg::*;
#(
    parameter int WORD_W = 30
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       rnd,
    input  logic              coded,
    input  logic [WORD_W-1:0] word_in,
    input  ch_byte_t          density,
    input  ch_byte_t          err_count,
    input  logic              noise_go,
    input  logic              err_go,
    output logic [WORD_W-1:0] word_out,
    output logic              noise_done,
    output logic              err_done
);

    localparam int BYTE_W = $bits(ch_byte_t);
    localparam int IDX_W  = $clog2(WORD_W);
    localparam int BIDX_W = $clog2(BYTE_W);

    logic [WORD_W-1:0] mask;
    logic [WORD_W-1:0] flipped;
    logic [IDX_W-1:0]  idx;
    logic              hit;
    logic              err_busy;
    ch_byte_t          n_pos;
    ch_byte_t          target;
    ch_byte_t          flips;
    ch_byte_t          flips_nxt;

    // density byte repeated over the word, uncoded data only has the low byte
    always_comb begin
        for (int i = 0; i < WORD_W; i++) begin
            mask[i] = density[i % BYTE_W] & (coded | (i < BYTE_W));
        end
    end

    // ------------------------------
    // error position pick
    // ------------------------------
    assign n_pos     = coded ? ch_byte_t'(WORD_W) : ch_byte_t'(BYTE_W);
    assign idx       = coded ? rnd[IDX_W-1:0] : IDX_W'(rnd[BIDX_W-1:0]);
    // out of range or already flipped, try again next cycle
    assign hit       = err_busy && (ch_byte_t'(idx) < n_pos) && !flipped[idx];
    assign flips_nxt = flips + 8'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            err_busy   <= 1'b0;
            flips      <= '0;
            target     <= '0;
            noise_done <= 1'b0;
            err_done   <= 1'b0;
        end else begin
            noise_done <= noise_go;
            err_done   <= 1'b0;
            if (err_go) begin
                flips  <= '0;
                target <= (err_count < n_pos) ? err_count : n_pos;
                // zero errors asked, done at once
                if (err_count == '0) begin
                    err_done <= 1'b1;
                end else begin
                    err_busy <= 1'b1;
                end
            end else if (hit) begin
                flips <= flips_nxt;
                if (flips_nxt == target) begin
                    err_busy <= 1'b0;
                    err_done <= 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // working word
    // ------------------------------
    always_ff @(posedge clk) begin
        if (noise_go) begin
            word_out <= word_in ^ (rnd[WORD_W-1:0] & mask);
        end else if (err_go) begin
            word_out <= word_in;
            flipped  <= '0;
        end else if (hit) begin
            word_out[idx] <= ~word_out[idx];
            flipped[idx]  <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: noise_source.sv
`default_nettype none

`include "channel_settings.svh"

module noise_source (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] rnd
);

    logic [31:0] rnd_nxt;

    // ------------------------------
    // Galois LFSR
    // ------------------------------
    // shift right and fold the taps in when a one drops out
    assign rnd_nxt = {1'b0, rnd[31:1]} ^ (rnd[0] ? `LFSR_TAPS : 32'h0);

    // free running, every consumer samples whatever word is current
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rnd <= `LFSR_SEED;
        end else begin
            rnd <= rnd_nxt;
        end
    end

endmodule

`default_nettype wire

// File: bch_encoder.sv
`default_nettype none

`include "channel_settings.svh"

module bch_encoder
    import bch_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  bch_msg_t msg,
    output bch_cw_t  cw,
    output logic     done
);

    localparam int R_W = `BCH_N - `BCH_K;
    localparam logic [R_W:0] GEN = `BCH_GEN;

    logic           busy;
    logic [2:0]     step;
    bch_msg_t       msg_q;
    logic [R_W-1:0] rem;
    logic           fb;
    logic [R_W-1:0] rem_nxt;

    // one division step, message taken msb first
    assign fb      = msg_q[`BCH_K-1-step] ^ rem[R_W-1];
    assign rem_nxt = {rem[R_W-2:0], 1'b0} ^ (fb ? GEN[R_W-1:0] : '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 3'd1;
                if (step == 3'(`BCH_K - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // codeword is loaded with the last remainder and held
    always_ff @(posedge clk) begin
        if (start) begin
            msg_q <= msg;
            rem   <= '0;
        end else if (busy) begin
            rem <= rem_nxt;
            if (step == 3'(`BCH_K - 1)) begin
                cw <= {msg_q, rem_nxt};
            end
        end
    end

endmodule

`default_nettype wire

// File: channel_pkg.sv
`default_nettype none

`include "channel_settings.svh"

package channel_pkg;

    import bch_pkg::*;

    typedef logic [`CH_DATA_W-1:0] ch_byte_t;

    // ------------------------------
    // command from the outside
    // ------------------------------
    typedef struct packed {
        ch_byte_t data;
        logic     use_bch;
        logic     use_noise;
        logic     use_errors;
        ch_byte_t density;
        ch_byte_t err_count;
    } channel_cmd_t;

    // sequencer stages
    typedef enum logic [2:0] {
        IDLE,
        ENCODING,
        NOISE,
        ERRORS,
        FINISHED
    } stage_t;

    // frame is zero for uncoded data
    typedef struct packed {
        ch_byte_t   data_out;
        bch_frame_t frame;
    } channel_result_t;

endpackage

`default_nettype wire

// File: bch_pkg.sv
`default_nettype none

`include "channel_settings.svh"

package bch_pkg;

    // one data nibble, top bit always zero
    typedef logic [`BCH_K-1:0] bch_msg_t;

    // message in the upper bits, parity below it
    typedef logic [`BCH_N-1:0] bch_cw_t;

    // ------------------------------
    // coded channel word
    // ------------------------------
    // hi carries the upper data nibble
    typedef struct packed {
        bch_cw_t hi;
        bch_cw_t lo;
    } bch_frame_t;

endpackage

`default_nettype wire

// File: channel_settings.svh
`ifndef CHANNEL_SETTINGS_SVH
`define CHANNEL_SETTINGS_SVH

// width of the user data
`define CH_DATA_W 8

// ------------------------------
// BCH(15,5) code
// ------------------------------
`define BCH_N 15
`define BCH_K 5

// g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
`define BCH_GEN 11'b10100110111

// ------------------------------
// random source
// ------------------------------
`define LFSR_SEED 32'h5EED_C0DE

// right-shift Galois feedback mask
`define LFSR_TAPS 32'h8020_0003

`endif
